// ==== tia_playfield.f ====
tia_pkg.sv
tia_line_counter.sv
tia_playfield_registers.sv
tia_colour_output.sv
tia_playfield_top.sv
tia_playfield_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tia_playfield_tb \
    -f tia_playfield.f -o tia_playfield_sim

out=$(./obj_dir/tia_playfield_sim || true)
echo "$out"

if echo "$out" | grep -qF '** PASS **'; then
    exit 0
fi
exit 1

// ==== tia_playfield_tb.sv ====
module tia_playfield_tb;

    localparam int LINE_PIXELS = 228;

    // Thirteen lines of tests at most plus margin
    localparam int TIMEOUT_CYCLES = 13 * LINE_PIXELS + 1000;

    logic             clkp_i;
    logic             rst_n_i;
    tia_pkg::tia_wr_t wr_i;
    tia_pkg::pixel_t  pix_o;

    // Shadow copies of the DUT registers
    tia_pkg::reg_data_t pf0_sh;
    tia_pkg::reg_data_t pf1_sh;
    tia_pkg::reg_data_t pf2_sh;
    tia_pkg::reg_data_t ctrlpf_sh;
    tia_pkg::colour_t   colup0_sh;
    tia_pkg::colour_t   colup1_sh;
    tia_pkg::colour_t   colupf_sh;
    tia_pkg::colour_t   colubk_sh;

    tia_pkg::pixel_t line_buf [LINE_PIXELS];
    tia_pkg::pixel_t prev_buf [LINE_PIXELS];
    logic [31:0]     lcg_state;
    int              cycle_count = 0;

    tia_playfield_top u_dut (
        .clkp_i  (clkp_i),
        .rst_n_i (rst_n_i),
        .wr_i    (wr_i),
        .pix_o   (pix_o)
    );

    initial begin
        clkp_i = 1'b0;
        forever #2 clkp_i = ~clkp_i;
    end

    always @(posedge clkp_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("** FAIL **");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    function automatic tia_pkg::reg_data_t next_random_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:24];
    endfunction

    task automatic check(input logic [31:0] expected, input logic [31:0] actual,
                         input string msg);
        if (expected !== actual) begin
            $display("FAIL at time %0t: %s, expected %h, got %h",
                     $time, msg, expected, actual);
            $display("** FAIL **");
            $fatal(1, "mismatch in pixel output");
        end
    endtask

    task automatic write_reg(input tia_pkg::reg_addr_t addr, input tia_pkg::reg_data_t data);
        @(posedge clkp_i);
        wr_i <= '{we: 1'b1, addr: addr, data: data};
        @(posedge clkp_i);
        wr_i <= '{we: 1'b0, addr: '0, data: '0};
        case (addr)
            tia_pkg::ADDR_COLUP0: colup0_sh = data[7:1];
            tia_pkg::ADDR_COLUP1: colup1_sh = data[7:1];
            tia_pkg::ADDR_COLUPF: colupf_sh = data[7:1];
            tia_pkg::ADDR_COLUBK: colubk_sh = data[7:1];
            tia_pkg::ADDR_CTRLPF: ctrlpf_sh = data;
            tia_pkg::ADDR_PF0:    pf0_sh = data;
            tia_pkg::ADDR_PF1:    pf1_sh = data;
            tia_pkg::ADDR_PF2:    pf2_sh = data;
            default: ;
        endcase
    endtask

    // Outputs are sampled on the falling edge
    task automatic wait_line_start();
        do begin
            @(negedge clkp_i);
        end while (pix_o.hpos != 8'd0);
    endtask

    // Place j of the forward order PF0 4..7 then PF1 7..0 then PF2 0..7
    function automatic logic forward_bit(input int j);
        if (j < 4) begin
            return pf0_sh[4 + j];
        end else if (j < 12) begin
            return pf1_sh[11 - j];
        end else begin
            return pf2_sh[j - 12];
        end
    endfunction

    function automatic tia_pkg::pixel_t expected_pixel(input tia_pkg::hpos_t h);
        tia_pkg::pixel_t p;
        int              hv;
        int              k;
        int              j;
        logic            pf;
        hv       = int'(h);
        p.hpos   = h;
        p.blank  = 1'b0;
        p.colour = '0;
        pf       = 1'b0;
        if (hv < 68) begin
            p.blank = 1'b1;
            return p;
        end
        k = (hv - 68) / 4;
        if (k < 20) begin
            j = k;
        end else begin
            j = ctrlpf_sh[0] ? 39 - k : k - 20;
        end
        pf = forward_bit(j);
        if (pf && ctrlpf_sh[1]) begin
            p.colour = (hv < 148) ? colup0_sh : colup1_sh;
        end else if (pf) begin
            p.colour = colupf_sh;
        end else begin
            p.colour = colubk_sh;
        end
        return p;
    endfunction

    // Checks one full line from hpos 0 and keeps it in line_buf
    task automatic check_line(input string name);
        tia_pkg::pixel_t exp;
        wait_line_start();
        for (int i = 0; i < LINE_PIXELS; i++) begin
            if (i > 0) begin
                @(negedge clkp_i);
            end
            exp = expected_pixel(tia_pkg::hpos_t'(i));
            line_buf[i] = pix_o;
            check({16'd0, exp}, {16'd0, pix_o}, $sformatf("%s pixel %0d", name, i));
        end
    endtask

    task automatic test_reset();
        check_line("reset");
    endtask

    task automatic test_background();
        wait_line_start();
        write_reg(tia_pkg::ADDR_COLUBK, next_random_byte());
        write_reg(tia_pkg::ADDR_COLUPF, next_random_byte());
        check_line("background");
    endtask

    task automatic test_repeat();
        tia_pkg::reg_data_t bk;
        bk = next_random_byte();
        wait_line_start();
        write_reg(tia_pkg::ADDR_CTRLPF, 8'h00);
        write_reg(tia_pkg::ADDR_COLUBK, bk);
        write_reg(tia_pkg::ADDR_COLUPF, bk ^ 8'h50);
        write_reg(tia_pkg::ADDR_PF0, next_random_byte());
        write_reg(tia_pkg::ADDR_PF1, next_random_byte());
        write_reg(tia_pkg::ADDR_PF2, next_random_byte());
        check_line("repeat");
        for (int h = 148; h < LINE_PIXELS; h++) begin
            check({25'd0, line_buf[h - 80].colour}, {25'd0, line_buf[h].colour},
                  $sformatf("repeat halves pixel %0d", h));
        end
    endtask

    task automatic test_reflect();
        wait_line_start();
        write_reg(tia_pkg::ADDR_CTRLPF, 8'h01);
        check_line("reflect");
        for (int h = 148; h < LINE_PIXELS; h++) begin
            check({25'd0, line_buf[295 - h].colour}, {25'd0, line_buf[h].colour},
                  $sformatf("reflect mirror pixel %0d", h));
        end
    endtask

    task automatic test_score();
        tia_pkg::reg_data_t p0;
        p0 = next_random_byte();
        wait_line_start();
        write_reg(tia_pkg::ADDR_CTRLPF, 8'h02);
        write_reg(tia_pkg::ADDR_COLUP0, p0);
        write_reg(tia_pkg::ADDR_COLUP1, p0 + 8'h10);
        write_reg(tia_pkg::ADDR_COLUPF, p0 + 8'h20);
        write_reg(tia_pkg::ADDR_COLUBK, p0 + 8'h30);
        // Set one bit near each end so both halves show playfield
        write_reg(tia_pkg::ADDR_PF0, next_random_byte() | 8'h10);
        write_reg(tia_pkg::ADDR_PF1, next_random_byte());
        write_reg(tia_pkg::ADDR_PF2, next_random_byte() | 8'h80);
        check_line("score");
    endtask

    task automatic test_ignored_addresses();
        check_line("ignored before");
        prev_buf = line_buf;
        wait_line_start();
        write_reg(6'h0B, next_random_byte());
        write_reg(6'h0C, next_random_byte());
        write_reg(6'h1D, next_random_byte());
        write_reg(6'h3F, next_random_byte());
        check_line("ignored after");
        for (int i = 0; i < LINE_PIXELS; i++) begin
            check({16'd0, prev_buf[i]}, {16'd0, line_buf[i]},
                  $sformatf("ignored repeat pixel %0d", i));
        end
    endtask

    initial begin
        rst_n_i   = 1'b0;
        wr_i      = '{we: 1'b0, addr: '0, data: '0};
        lcg_state = 32'ha4f61b07;
        pf0_sh    = '0;
        pf1_sh    = '0;
        pf2_sh    = '0;
        ctrlpf_sh = '0;
        colup0_sh = '0;
        colup1_sh = '0;
        colupf_sh = '0;
        colubk_sh = '0;
        repeat (2) @(posedge clkp_i);
        rst_n_i <= 1'b1;
        // Let the reset value of pix_o pass before looking for hpos 0
        repeat (4) @(posedge clkp_i);

        test_reset();
        test_background();
        test_repeat();
        test_reflect();
        test_score();
        test_ignored_addresses();

        $display("** PASS **");
        $finish;
    end

endmodule

// ==== tia_playfield_top.sv ====
module tia_playfield_top (
    input  logic             clkp_i,
    input  logic             rst_n_i,
    input  tia_pkg::tia_wr_t wr_i,
    output tia_pkg::pixel_t  pix_o
);

    tia_pkg::hpos_t hpos;
    logic           hblank;
    logic           line_start;
    logic           centre;
    logic           pf_step;
    logic           reflect;
    logic           pf_bit;

    // Stage 0
    tia_line_counter u_line_counter (
        .clkp_i       (clkp_i),
        .rst_n_i      (rst_n_i),
        .hpos_o       (hpos),
        .hblank_o     (hblank),
        .line_start_o (line_start),
        .centre_o     (centre),
        .pf_step_o    (pf_step)
    );

    // Stage 1
    tia_playfield_registers u_playfield_registers (
        .clkp_i       (clkp_i),
        .rst_n_i      (rst_n_i),
        .wr_i         (wr_i),
        .line_start_i (line_start),
        .centre_i     (centre),
        .pf_step_i    (pf_step),
        .reflect_i    (reflect),
        .pf_o         (pf_bit)
    );

    // Stage 2
    tia_colour_output u_colour_output (
        .clkp_i    (clkp_i),
        .rst_n_i   (rst_n_i),
        .wr_i      (wr_i),
        .hpos_i    (hpos),
        .hblank_i  (hblank),
        .pf_i      (pf_bit),
        .reflect_o (reflect),
        .pix_o     (pix_o)
    );

endmodule

// ==== tia_colour_output.sv ====
module tia_colour_output (
    input  logic             clkp_i,
    input  logic             rst_n_i,
    input  tia_pkg::tia_wr_t wr_i,
    input  tia_pkg::hpos_t   hpos_i,
    input  logic             hblank_i,
    input  logic             pf_i,
    output logic             reflect_o,
    output tia_pkg::pixel_t  pix_o
);

    tia_pkg::colour_t colup0_q;
    tia_pkg::colour_t colup1_q;
    tia_pkg::colour_t colupf_q;
    tia_pkg::colour_t colubk_q;
    logic             reflect_q;
    logic             score_q;
    tia_pkg::hpos_t   hpos_d;
    logic             hblank_d;
    tia_pkg::colour_t pf_colour;
    tia_pkg::colour_t colour_next;

    // Colour registers take data bits 7:1 and ignore bit 0
    always_ff @(posedge clkp_i) begin
        if (!rst_n_i) begin
            colup0_q  <= '0;
            colup1_q  <= '0;
            colupf_q  <= '0;
            colubk_q  <= '0;
            reflect_q <= 1'b0;
            score_q   <= 1'b0;
        end else if (wr_i.we) begin
            case (wr_i.addr)
                tia_pkg::ADDR_COLUP0: colup0_q <= wr_i.data[7:1];
                tia_pkg::ADDR_COLUP1: colup1_q <= wr_i.data[7:1];
                tia_pkg::ADDR_COLUPF: colupf_q <= wr_i.data[7:1];
                tia_pkg::ADDR_COLUBK: colubk_q <= wr_i.data[7:1];
                tia_pkg::ADDR_CTRLPF: begin
                    reflect_q <= wr_i.data[0];
                    score_q   <= wr_i.data[1];
                end
                default: ;
            endcase
        end
    end

    assign reflect_o = reflect_q;

    // Line position delayed one stage to line up with pf_i
    always_ff @(posedge clkp_i) begin
        if (!rst_n_i) begin
            hpos_d   <= '0;
            hblank_d <= 1'b1;
        end else begin
            hpos_d   <= hpos_i;
            hblank_d <= hblank_i;
        end
    end

    // Score mode colours each half with its player colour
    always_comb begin
        if (score_q) begin
            pf_colour = (hpos_d < tia_pkg::CENTRE_HPOS) ? colup0_q : colup1_q;
        end else begin
            pf_colour = colupf_q;
        end
        if (hblank_d) begin
            colour_next = '0;
        end else if (pf_i) begin
            colour_next = pf_colour;
        end else begin
            colour_next = colubk_q;
        end
    end

    always_ff @(posedge clkp_i) begin
        if (!rst_n_i) begin
            pix_o <= '{hpos: '0, blank: 1'b1, colour: '0};
        end else begin
            pix_o <= '{hpos: hpos_d, blank: hblank_d, colour: colour_next};
        end
    end

    blank_is_black: assert property (
        @(posedge clkp_i) disable iff (!rst_n_i)
        pix_o.blank |-> (pix_o.colour == '0)
    );

endmodule

// ==== tia_playfield_registers.sv ====
module tia_playfield_registers (
    input  logic             clkp_i,
    input  logic             rst_n_i,
    input  tia_pkg::tia_wr_t wr_i,
    input  logic             line_start_i,
    input  logic             centre_i,
    input  logic             pf_step_i,
    input  logic             reflect_i,
    output logic             pf_o
);

    // First and last place of the forward scan order
    localparam tia_pkg::pf_token_t TOKEN_FIRST = 20'h00001;
    localparam tia_pkg::pf_token_t TOKEN_LAST  = 20'h80000;

    logic [3:0]         pf0_q;
    tia_pkg::reg_data_t pf1_q;
    tia_pkg::reg_data_t pf2_q;
    tia_pkg::pf_token_t pf_pattern;
    tia_pkg::pf_token_t token_q;
    logic               reverse_q;
    logic               wr_pf0;
    logic               wr_pf1;
    logic               wr_pf2;

    assign wr_pf0 = wr_i.we && (wr_i.addr == tia_pkg::ADDR_PF0);
    assign wr_pf1 = wr_i.we && (wr_i.addr == tia_pkg::ADDR_PF1);
    assign wr_pf2 = wr_i.we && (wr_i.addr == tia_pkg::ADDR_PF2);

    // PF0 keeps only its upper nibble
    always_ff @(posedge clkp_i) begin
        if (!rst_n_i) begin
            pf0_q <= '0;
            pf1_q <= '0;
            pf2_q <= '0;
        end else begin
            if (wr_pf0) begin
                pf0_q <= wr_i.data[7:4];
            end
            if (wr_pf1) begin
                pf1_q <= wr_i.data;
            end
            if (wr_pf2) begin
                pf2_q <= wr_i.data;
            end
        end
    end

    // Register bits laid out in scan order
    // PF0 4..7, then PF1 7..0, then PF2 0..7
    always_comb begin
        pf_pattern[3:0] = pf0_q;
        for (int i = 0; i < 8; i++) begin
            pf_pattern[4 + i]  = pf1_q[7 - i];
            pf_pattern[12 + i] = pf2_q[i];
        end
    end

    // One-hot token that walks forward or backward and drops off either end
    // Only a reflected right half runs backward
    always_ff @(posedge clkp_i) begin
        if (!rst_n_i) begin
            token_q   <= '0;
            reverse_q <= 1'b0;
        end else if (line_start_i) begin
            token_q   <= TOKEN_FIRST;
            reverse_q <= 1'b0;
        end else if (centre_i) begin
            token_q   <= reflect_i ? TOKEN_LAST : TOKEN_FIRST;
            reverse_q <= reflect_i;
        end else if (pf_step_i) begin
            if (reverse_q) begin
                token_q <= token_q >> 1;
            end else begin
                token_q <= token_q << 1;
            end
        end
    end

    // Stage 1 playfield bit
    always_ff @(posedge clkp_i) begin
        if (!rst_n_i) begin
            pf_o <= 1'b0;
        end else begin
            pf_o <= |(pf_pattern & token_q);
        end
    end

    token_onehot0: assert property (
        @(posedge clkp_i) disable iff (!rst_n_i)
        $onehot0(token_q)
    );

    // Previous line must have run the token off its end during blanking
    token_idle_at_line_start: assert property (
        @(posedge clkp_i) disable iff (!rst_n_i)
        line_start_i |-> (token_q == '0)
    );

endmodule

// ==== tia_line_counter.sv ====
module tia_line_counter (
    input  logic          clkp_i,
    input  logic          rst_n_i,
    output tia_pkg::hpos_t hpos_o,
    output logic          hblank_o,
    output logic          line_start_o,
    output logic          centre_o,
    output logic          pf_step_o
);

    tia_pkg::hpos_t hpos_q;
    logic [1:0]     phase_q;

    // Position within the line, wraps after the last pixel
    always_ff @(posedge clkp_i) begin
        if (!rst_n_i) begin
            hpos_q <= '0;
        end else if (hpos_q == tia_pkg::LINE_CLKS - 8'd1) begin
            hpos_q <= '0;
        end else begin
            hpos_q <= hpos_q + 8'd1;
        end
    end

    // Sub-pixel phase, blanking and line length are both multiples of 4
    always_ff @(posedge clkp_i) begin
        if (!rst_n_i) begin
            phase_q <= 2'd0;
        end else begin
            phase_q <= phase_q + 2'd1;
        end
    end

    assign hpos_o   = hpos_q;
    assign hblank_o = (hpos_q < tia_pkg::HBLANK_CLKS);

    // Last blanking pixel, token loads for the left half
    assign line_start_o = (hpos_q == tia_pkg::HBLANK_CLKS - 8'd1);

    // Last left-half pixel
    assign centre_o = (hpos_q == tia_pkg::CENTRE_HPOS - 8'd1);

    // Last pixel of each four-pixel playfield cell
    assign pf_step_o = (phase_q == 2'd3);

    hpos_in_range: assert property (
        @(posedge clkp_i) disable iff (!rst_n_i)
        hpos_q < tia_pkg::LINE_CLKS
    );

    phase_tracks_hpos: assert property (
        @(posedge clkp_i) disable iff (!rst_n_i)
        phase_q == hpos_q[1:0]
    );

endmodule

// ==== tia_pkg.sv ====
package tia_pkg;

    // Vector types
    typedef logic [5:0]  reg_addr_t;
    typedef logic [7:0]  reg_data_t;
    typedef logic [7:0]  hpos_t;
    typedef logic [6:0]  colour_t;
    typedef logic [19:0] pf_token_t;

    // Write bus, one strobe per register write
    typedef struct packed {
        logic      we;
        reg_addr_t addr;
        reg_data_t data;
    } tia_wr_t;

    // Pixel stream, one per pixel clock
    typedef struct packed {
        hpos_t   hpos;
        logic    blank;
        colour_t colour;
    } pixel_t;

    // Register map
    localparam reg_addr_t ADDR_COLUP0 = 6'h06;
    localparam reg_addr_t ADDR_COLUP1 = 6'h07;
    localparam reg_addr_t ADDR_COLUPF = 6'h08;
    localparam reg_addr_t ADDR_COLUBK = 6'h09;
    localparam reg_addr_t ADDR_CTRLPF = 6'h0A;
    localparam reg_addr_t ADDR_PF0    = 6'h0D;
    localparam reg_addr_t ADDR_PF1    = 6'h0E;
    localparam reg_addr_t ADDR_PF2    = 6'h0F;

    // Line geometry in pixel clocks
    localparam hpos_t HBLANK_CLKS = 8'd68;
    localparam hpos_t LINE_CLKS   = 8'd228;
    localparam hpos_t CENTRE_HPOS = 8'd148;

endpackage
